// ==== filelist.f ====
source/gfxPkg.sv
source/gamePkg.sv
source/rasterIf.sv
source/rasterTimer.sv
source/playerSprite.sv
source/collisionDetector.sv
source/playerMotion.sv
source/gameControl.sv
source/gameTop.sv
verification/gameTop_chk.sv
verification/gameTb.sv

// ==== source/collisionDetector.sv ====
`timescale 1ns/1ps
`default_nettype none

module collisionDetector (
    input  logic              clk,
    input  logic              resetN,
    rasterIf.reader           raster,
    input  logic              playerHit,
    input  gamePkg::edgeCode  playerEdges,
    output gamePkg::edgeCode  blockedEdges   // sticky for one frame
);
    import gfxPkg::*;
    import gamePkg::*;

    pixelCoord delayX;      // scan position aligned with the sprite output
    pixelCoord delayY;
    edgeCode   bandSide;    // which border band the delayed pixel lies in
    edgeCode   hitEdges;

    always_ff @(posedge clk) begin
        delayX <= raster.pixelX;
        delayY <= raster.pixelY;
    end

    // band per side, a corner pixel belongs to two sides
    always_comb begin
        bandSide              = '0;
        bandSide[EDGE_LEFT]   = (delayX < pixelCoord'(BORDER_WIDTH));
        bandSide[EDGE_RIGHT]  = (delayX >= pixelCoord'(SCREEN_WIDTH - BORDER_WIDTH));
        bandSide[EDGE_TOP]    = (delayY < pixelCoord'(BORDER_WIDTH));
        bandSide[EDGE_BOTTOM] = (delayY >= pixelCoord'(SCREEN_HEIGHT - BORDER_WIDTH));
    end

    // a player edge only counts against the border on its own side,
    // so a top row running into the right band does not block vertical motion
    assign hitEdges = playerHit ? (playerEdges & bandSide) : '0;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            blockedEdges <= '0;
        end else if (raster.startOfFrame) begin
            blockedEdges <= '0;                        // motion has sampled the old frame
        end else begin
            blockedEdges <= blockedEdges | hitEdges;   // accumulate over the frame
        end
    end

endmodule

`default_nettype wire

// ==== source/gameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameControl (
    input  logic              clk,
    input  logic              resetN,
    rasterIf.reader           raster,
    input  logic              start,
    input  gfxPkg::pixelCoord topLeftX,
    input  gfxPkg::pixelCoord topLeftY,
    output logic              moveEnable,
    output logic              reportValid,
    input  logic              reportReady,
    output gfxPkg::pixelCoord reportX,
    output gfxPkg::pixelCoord reportY
);
    import gamePkg::*;

    ctrlState state;
    logic     frameMoved;   // position was stepped on the last cycle

    // motion only while playing with no report outstanding
    assign moveEnable = (state == PLAY);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state       <= IDLE;
            reportValid <= 1'b0;
            frameMoved  <= 1'b0;
        end else begin
            frameMoved <= raster.startOfFrame && moveEnable;
            case (state)
                IDLE: begin
                    if (start && raster.active) begin
                        state <= PLAY;              // first step at the next frame
                    end
                end
                PLAY: begin
                    if (frameMoved) begin
                        state       <= HOLD;
                        reportValid <= 1'b1;        // new position goes out
                    end
                end
                HOLD: begin
                    if (reportReady) begin          // transfer on this edge
                        state       <= PLAY;
                        reportValid <= 1'b0;
                    end
                end
                default: begin
                    state       <= IDLE;
                    reportValid <= 1'b0;
                end
            endcase
        end
    end

    // report data, loaded with the same edge that raises valid
    always_ff @(posedge clk) begin
        if (frameMoved && (state == PLAY)) begin
            reportX <= topLeftX;
            reportY <= topLeftY;
        end
    end

endmodule

`default_nettype wire

// ==== source/gamePkg.sv ====
`default_nettype none

package gamePkg;

    // positions keep 1/64 pixel of fraction
    localparam int FIXED_SHIFT = 6;

    typedef logic signed [31:0] fixedPos;  // pixel position scaled by 2**FIXED_SHIFT

    localparam int SPEED = 128;            // 2 pixels per frame in fixed point

    // player square
    localparam int PLAYER_SIZE = 8;
    localparam int INITIAL_X   = 36;       // roughly centred
    localparam int INITIAL_Y   = 26;

    // solid band along every screen edge
    localparam int BORDER_WIDTH = 2;

    // one bit per side of an object
    typedef logic [3:0] edgeCode;

    localparam int EDGE_BOTTOM = 0;
    localparam int EDGE_RIGHT  = 1;
    localparam int EDGE_TOP    = 2;
    localparam int EDGE_LEFT   = 3;

    // game control FSM
    typedef enum logic [1:0] {
        IDLE,                              // waiting for start
        PLAY,                              // motion enabled
        HOLD                               // report pending, motion frozen
    } ctrlState;

endpackage

`default_nettype wire

// ==== source/gameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameTop (
    input  logic              clk,
    input  logic              resetN,
    input  logic              start,        // leave idle
    input  logic              moveLeft,
    input  logic              moveRight,
    input  logic              moveUp,
    input  logic              moveDown,
    input  logic              reportReady,
    output logic              reportValid,
    output gfxPkg::pixelCoord reportX,      // player top left after the frame step
    output gfxPkg::pixelCoord reportY
);
    import gfxPkg::*;
    import gamePkg::*;

    rasterIf raster ();       // shared scan position and frame pulse

    pixelCoord topLeftX;      // current player position in pixels
    pixelCoord topLeftY;
    logic      playerHit;
    edgeCode   playerEdges;
    edgeCode   blockedEdges;
    logic      moveEnable;

    rasterTimer timer (
        .clk    (clk),
        .resetN (resetN),
        .raster (raster)
    );

    // per pixel player coverage
    playerSprite sprite (
        .clk         (clk),
        .resetN      (resetN),
        .raster      (raster),
        .topLeftX    (topLeftX),
        .topLeftY    (topLeftY),
        .playerHit   (playerHit),
        .playerEdges (playerEdges)
    );

    collisionDetector detector (
        .clk          (clk),
        .resetN       (resetN),
        .raster       (raster),
        .playerHit    (playerHit),
        .playerEdges  (playerEdges),
        .blockedEdges (blockedEdges)
    );

    playerMotion motion (
        .clk          (clk),
        .resetN       (resetN),
        .raster       (raster),
        .moveLeft     (moveLeft),
        .moveRight    (moveRight),
        .moveUp       (moveUp),
        .moveDown     (moveDown),
        .moveEnable   (moveEnable),
        .blockedEdges (blockedEdges),
        .topLeftX     (topLeftX),
        .topLeftY     (topLeftY)
    );

    // FSM and report handshake
    gameControl control (
        .clk         (clk),
        .resetN      (resetN),
        .raster      (raster),
        .start       (start),
        .topLeftX    (topLeftX),
        .topLeftY    (topLeftY),
        .moveEnable  (moveEnable),
        .reportValid (reportValid),
        .reportReady (reportReady),
        .reportX     (reportX),
        .reportY     (reportY)
    );

endmodule

`default_nettype wire

// ==== source/gfxPkg.sv ====
`default_nettype none

package gfxPkg;

    // reduced virtual screen, one pixel per clock and no blanking
    localparam int SCREEN_WIDTH  = 80;
    localparam int SCREEN_HEIGHT = 60;

    // coordinate width leaves room for objects partly off screen
    localparam int PIXEL_WIDTH = 11;

    // last scanned column and line of a frame
    localparam int LAST_X = SCREEN_WIDTH - 1;
    localparam int LAST_Y = SCREEN_HEIGHT - 1;

    // every screen coordinate, signed so a sprite may sit left of or above the screen
    typedef logic signed [PIXEL_WIDTH-1:0] pixelCoord;

endpackage

`default_nettype wire

// ==== source/playerMotion.sv ====
`timescale 1ns/1ps
`default_nettype none

module playerMotion (
    input  logic              clk,
    input  logic              resetN,
    rasterIf.reader           raster,
    input  logic              moveLeft,
    input  logic              moveRight,
    input  logic              moveUp,
    input  logic              moveDown,
    input  logic              moveEnable,     // low while a report waits
    input  gamePkg::edgeCode  blockedEdges,   // edges hit during the last frame
    output gfxPkg::pixelCoord topLeftX,
    output gfxPkg::pixelCoord topLeftY
);
    import gfxPkg::*;
    import gamePkg::*;

    fixedPos posX;         // 1/64 pixel position
    fixedPos posY;
    fixedPos speedX;       // follows the buttons one cycle later
    fixedPos speedY;
    fixedPos nextSpeedX;
    fixedPos nextSpeedY;

    // x axis, exactly one button pressed and that side free
    always_comb begin
        nextSpeedX = '0;
        if (moveRight && !moveLeft) begin
            if (!blockedEdges[EDGE_RIGHT]) begin
                nextSpeedX = fixedPos'(SPEED);
            end
        end else if (moveLeft && !moveRight) begin
            if (!blockedEdges[EDGE_LEFT]) begin
                nextSpeedX = -fixedPos'(SPEED);
            end
        end
    end

    // y axis grows downwards
    always_comb begin
        nextSpeedY = '0;
        if (moveDown && !moveUp) begin
            if (!blockedEdges[EDGE_BOTTOM]) begin
                nextSpeedY = fixedPos'(SPEED);
            end
        end else if (moveUp && !moveDown) begin
            if (!blockedEdges[EDGE_TOP]) begin
                nextSpeedY = -fixedPos'(SPEED);   // up
            end
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            speedX <= '0;
            speedY <= '0;
            posX   <= fixedPos'(INITIAL_X) <<< FIXED_SHIFT;
            posY   <= fixedPos'(INITIAL_Y) <<< FIXED_SHIFT;
        end else begin
            speedX <= nextSpeedX;
            speedY <= nextSpeedY;
            if (raster.startOfFrame && moveEnable) begin   // one step per frame
                posX <= posX + speedX;
                posY <= posY + speedY;
            end
        end
    end

    // drop the fraction, arithmetic shift keeps negative positions
    assign topLeftX = pixelCoord'(posX >>> FIXED_SHIFT);
    assign topLeftY = pixelCoord'(posY >>> FIXED_SHIFT);

endmodule

`default_nettype wire

// ==== source/playerSprite.sv ====
`timescale 1ns/1ps
`default_nettype none

module playerSprite (
    input  logic               clk,
    input  logic               resetN,
    rasterIf.reader            raster,
    input  gfxPkg::pixelCoord  topLeftX,
    input  gfxPkg::pixelCoord  topLeftY,
    output logic               playerHit,    // scanned pixel is on the player
    output gamePkg::edgeCode   playerEdges   // outermost rows or columns at that pixel
);
    import gfxPkg::*;
    import gamePkg::*;

    pixelCoord rightX;    // last player column
    pixelCoord bottomY;   // last player row
    logic      insideX;
    logic      insideY;
    edgeCode   edgesNow;

    assign rightX  = topLeftX + pixelCoord'(PLAYER_SIZE - 1);
    assign bottomY = topLeftY + pixelCoord'(PLAYER_SIZE - 1);

    assign insideX = (raster.pixelX >= topLeftX) && (raster.pixelX <= rightX);
    assign insideY = (raster.pixelY >= topLeftY) && (raster.pixelY <= bottomY);

    // edge flags only count inside the square
    always_comb begin
        edgesNow = '0;
        if (insideX && insideY) begin
            edgesNow[EDGE_TOP]    = (raster.pixelY == topLeftY);
            edgesNow[EDGE_BOTTOM] = (raster.pixelY == bottomY);
            edgesNow[EDGE_LEFT]   = (raster.pixelX == topLeftX);
            edgesNow[EDGE_RIGHT]  = (raster.pixelX == rightX);
        end
    end

    // one cycle of latency, matched in the detector
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            playerHit   <= 1'b0;
            playerEdges <= '0;
        end else begin
            playerHit   <= insideX && insideY;
            playerEdges <= edgesNow;
        end
    end

endmodule

`default_nettype wire

// ==== source/rasterIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rasterIf;
    import gfxPkg::*;

    pixelCoord pixelX;        // column being scanned
    pixelCoord pixelY;        // line being scanned
    logic      startOfFrame;  // single cycle at (0,0)
    logic      active;        // scan running

    // raster timer owns the scan
    modport timer (
        output pixelX,
        output pixelY,
        output startOfFrame,
        output active
    );

    // every other block only follows it
    modport reader (
        input pixelX,
        input pixelY,
        input startOfFrame,
        input active
    );

endinterface

`default_nettype wire

// ==== source/rasterTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rasterTimer (
    input  logic   clk,
    input  logic   resetN,
    rasterIf.timer raster
);
    import gfxPkg::*;

    pixelCoord xCount;   // current column
    pixelCoord yCount;   // current line
    logic      running;  // goes high one cycle after reset
    logic      lineEnd;
    logic      frameEnd;

    assign lineEnd  = (xCount == pixelCoord'(LAST_X));
    assign frameEnd = lineEnd && (yCount == pixelCoord'(LAST_Y));

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            xCount  <= '0;
            yCount  <= '0;
            running <= 1'b0;
        end else if (!running) begin
            running <= 1'b1;                     // first scan cycle sits at (0,0)
        end else if (frameEnd) begin
            xCount <= '0;                        // wrap to top left
            yCount <= '0;
        end else if (lineEnd) begin
            xCount <= '0;
            yCount <= yCount + pixelCoord'(1);   // next line
        end else begin
            xCount <= xCount + pixelCoord'(1);
        end
    end

    assign raster.pixelX = xCount;
    assign raster.pixelY = yCount;
    assign raster.active = running;

    // one pulse per 4800 clock frame
    assign raster.startOfFrame = running && (xCount == '0) && (yCount == '0);

endmodule

`default_nettype wire

// ==== verification/gameTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameTb;
    import gfxPkg::*;

    logic        clk;
    logic        resetN;
    logic        start;
    logic        moveLeft;
    logic        moveRight;
    logic        moveUp;
    logic        moveDown;
    logic        reportReady;
    logic        reportValid;
    pixelCoord   reportX;
    pixelCoord   reportY;
    int          errorCount;    // failed value checks
    int          testCount;
    int          testsFailed;
    logic        timedOut;
    logic [31:0] lfsrState;     // random ready delays

    gameTop DUT (.*);

    always #50 clk = ~clk;      // 100 ns period

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawRandom(input int bits, output int value);
        value = 0;
        for (int i = 0; i < bits; i++) begin
            lfsrState = lfsrStep(lfsrState);        // one step per bit taken
            value     = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // inputs change and outputs are sampled 5 ns after the rising edge
    task automatic stepCycle();
        @(posedge clk);
        #5;
    endtask

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
        end
    endtask

    task automatic waitForReport(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 6000) begin        // a frame is 4800 cycles
            stepCycle();
            cycles++;
            seen = reportValid;
        end
    endtask

    // one report: buttons applied, handshake after the ready delay, position compared
    task automatic runStep(input logic [3:0] buttons, input int mode, input int delay,
                           input int expX, input int expY);
        logic seen;
        int   readyDelay;
        int   failsBefore;
        failsBefore = errorCount;
        readyDelay  = delay;
        {moveLeft, moveRight, moveUp, moveDown} = buttons;
        if (mode == 1) begin
            drawRandom(delay, readyDelay);          // delay column gives the bit count
        end
        waitForReport(seen);
        testCount++;
        if (!seen) begin
            $display("step %0d: no report within 6000 cycles, run stopped", testCount);
            timedOut = 1'b1;
            testsFailed++;
        end else begin
            repeat (readyDelay) stepCycle();        // back-pressure
            checkValue(int'(reportX), expX, "reportX");
            checkValue(int'(reportY), expY, "reportY");
            reportReady = 1'b1;
            stepCycle();                            // transfer edge
            reportReady = 1'b0;
            checkValue(int'(reportValid), 0, "reportValid after transfer");
            if (errorCount != failsBefore) testsFailed++;
            $display("step %0d buttons %b delay %0d report (%0d,%0d) %s", testCount, buttons,
                     readyDelay, expX, expY, (errorCount == failsBefore) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        int               fd;
        int               got;
        int               mode;
        int               delay;
        int               expX;
        int               expY;
        logic [3:0]       buttons;
        logic [8*120-1:0] lineText;
        logic             sawValid;
        clk         = 1'b0;
        resetN      = 1'b0;
        start       = 1'b0;
        {moveLeft, moveRight, moveUp, moveDown} = 4'b0000;
        reportReady = 1'b0;
        errorCount  = 0;
        testCount   = 0;
        testsFailed = 0;
        timedOut    = 1'b0;
        lfsrState   = 32'h4834;
        repeat (4) @(posedge clk);
        #5 resetN = 1'b1;

        // idle, two whole frames without a report
        sawValid = 1'b0;
        for (int i = 0; i < 2 * SCREEN_WIDTH * SCREEN_HEIGHT; i++) begin
            stepCycle();
            sawValid = sawValid | reportValid;
        end
        testCount++;
        checkValue(int'(sawValid), 0, "report before start");
        if (sawValid) testsFailed++;
        $display("step %0d idle for two frames %s", testCount, sawValid ? "mismatch" : "ok");
        start = 1'b1;
        stepCycle();
        start = 1'b0;

        fd = $fopen("verification/moveInput.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/moveInput.txt, motion steps not run");
            errorCount++;
        end else begin
            while (!$feof(fd) && !timedOut) begin
                lineText = '0;
                got = $fgets(lineText, fd);
                got = $sscanf(lineText, "%h %d %d %d %d", buttons, mode, delay, expX, expY);
                if (got == 5) begin                 // comment and blank lines skipped
                    runStep(buttons, mode, delay, expX, expY);
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 testCount, testsFailed, errorCount, DUT.handshakeChk.assertFails);
        if (errorCount == 0 && !timedOut && DUT.handshakeChk.assertFails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/gameTop_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameTopChk (
    input logic              clk,
    input logic              resetN,
    input logic              startOfFrame,
    input logic              moveEnable,
    input logic              reportValid,
    input logic              reportReady,
    input gfxPkg::pixelCoord reportX,
    input gfxPkg::pixelCoord reportY
);
    int assertFails = 0;   // assertion failures seen so far

    // no report may be pending while reset is held
    validInReset: assert property (@(posedge clk) !resetN |-> !reportValid)
        else begin
            assertFails++;
            $error("reportValid high during reset");
        end

    // a stalled report keeps valid and data until ready
    holdUntilReady: assert property (@(posedge clk) disable iff (!resetN)
        (reportValid && !reportReady) |=>
            (reportValid && $stable(reportX) && $stable(reportY)))
        else begin
            assertFails++;
            $error("report changed before reportReady");
        end

    singleFramePulse: assert property (@(posedge clk) disable iff (!resetN)
        startOfFrame |=> !startOfFrame)   // pulse only at (0,0)
        else begin
            assertFails++;
            $error("startOfFrame longer than one cycle");
        end

    // motion frozen while a report waits
    frozenWhileValid: assert property (@(posedge clk) disable iff (!resetN)
        reportValid |-> !moveEnable)
        else begin
            assertFails++;
            $error("moveEnable high while reportValid");
        end

endmodule

bind gameTop gameTopChk handshakeChk (
    .clk          (clk),
    .resetN       (resetN),
    .startOfFrame (raster.startOfFrame),
    .moveEnable   (moveEnable),
    .reportValid  (reportValid),
    .reportReady  (reportReady),
    .reportX      (reportX),
    .reportY      (reportY)
);

`default_nettype wire

// ==== verification/moveInput.txt ====
# buttons hex nibble L R U D, mode 0 delay in cycles or mode 1 delay from that many LFSR bits
# then the expected report x and y
0 0 0 36 26
4 0 0 38 26
1 1 6 38 28
8 0 3 36 28
2 0 0 36 26
c 1 6 36 26
3 0 1 36 26
6 0 0 38 24
6 0 0 40 22
6 1 6 42 20
6 0 0 44 18
6 0 2 46 16
6 0 0 48 14
6 0 0 50 12
6 1 6 52 10
6 0 0 54 8
6 0 0 56 6
6 0 5 58 4
6 0 0 60 2
6 0 0 62 0
6 0 0 64 0
6 1 6 66 0
6 0 0 68 0
6 0 0 70 0
6 0 0 72 0
6 0 0 72 0
8 0 10000 70 0
1 0 15000 70 2
